// File: compile.f
+incdir+source
source/lsu_pkg.sv
source/mem_port_if.sv
source/lsu_agu.sv
source/load_unit.sv
source/store_unit.sv
source/dmem_bank.sv
source/pipe_reg.sv
source/lsu_top.sv
testbench/tb_lsu.sv

// File: run.sh
#!/bin/sh
# Build the load/store unit testbench with Verilator and run it
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_lsu \
  && ./obj_dir/Vtb_lsu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"

// File: source/dmem_bank.sv
// Byte-enabled data scratchpad with a read port and a write port
// A read and a write in the same cycle return the old word, contents are not reset
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module dmem_bank (
  input  logic     clk_i,
  mem_port_if.mem  ld_port,
  mem_port_if.mem  st_port
);

  logic [`LSU_XLEN-1:0] mem_q [`LSU_DMEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (st_port.req && st_port.we) begin
      for (int b = 0; b < `LSU_XLEN/8; b++) begin
        if (st_port.be[b]) begin
          mem_q[st_port.addr][8*b +: 8] <= st_port.wdata[8*b +: 8];
        end
      end
    end
    // Registered read, valid the cycle after the request
    if (ld_port.req && !ld_port.we) begin
      ld_port.rdata <= mem_q[ld_port.addr];
    end
  end

  // Store port has no read path
  assign st_port.rdata = '0;

endmodule

`default_nettype wire

// File: source/load_unit.sv
// Scratchpad loads with sign or zero extension
// Read data arrives one cycle after the request, so the result follows the control stage
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module load_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lsu_pkg::lsu_ctrl_t  ctrl_i,
  mem_port_if.unit            mem,
  output lsu_pkg::ld_result_t result_o
);

  import lsu_pkg::*;

  logic                  is_load;
  logic                  valid_q;
  logic                  ex_q;
  lsu_op_e               op_q;
  logic [1:0]            offset_q;
  logic [TRANS_ID_W-1:0] trans_id_q;
  exc_cause_e            cause_q;
  logic [`LSU_XLEN-1:0]  addr_q;
  logic [`LSU_XLEN-1:0]  shifted;
  logic [`LSU_XLEN-1:0]  ld_data;

  assign is_load = ctrl_i.valid & ~ctrl_i.is_store;

  // Faulting loads never touch memory
  assign mem.req   = is_load & ~ctrl_i.ex_valid;
  assign mem.we    = 1'b0;
  assign mem.addr  = ctrl_i.vaddr[`LSU_WORD_AW+1:2];
  assign mem.be    = ctrl_i.be;
  assign mem.wdata = '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      ex_q    <= 1'b0;
    end else begin
      valid_q <= is_load;
      ex_q    <= is_load & ctrl_i.ex_valid;
    end
  end

  // What is needed to pick the data once it returns
  always_ff @(posedge clk_i) begin
    if (is_load) begin
      op_q       <= ctrl_i.op;
      offset_q   <= ctrl_i.vaddr[1:0];
      trans_id_q <= ctrl_i.trans_id;
      cause_q    <= ctrl_i.ex_cause;
      addr_q     <= ctrl_i.vaddr;
    end
  end

  // ------------------------------------------------------------
  // Alignment and extension
  // ------------------------------------------------------------
  assign shifted = mem.rdata >> {offset_q, 3'b000};

  always_comb begin
    case (op_q)
      LB:      ld_data = {{24{shifted[7]}}, shifted[7:0]};
      LBU:     ld_data = {24'b0, shifted[7:0]};
      LH:      ld_data = {{16{shifted[15]}}, shifted[15:0]};
      LHU:     ld_data = {16'b0, shifted[15:0]};
      default: ld_data = mem.rdata;
    endcase
  end

  always_comb begin
    result_o = '0;
    if (valid_q) begin
      result_o.valid    = 1'b1;
      result_o.trans_id = trans_id_q;
      if (ex_q) begin
        result_o.ex.valid = 1'b1;
        result_o.ex.cause = cause_q;
        result_o.ex.tval  = addr_q;
      end else begin
        result_o.data = ld_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/lsu_agu.sv
// Address generation and exception detection, one instruction per cycle
// Any address at or above the scratchpad size is an access fault
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module lsu_agu (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           valid_i,
  input  lsu_pkg::lsu_op_e               op_i,
  input  logic [`LSU_XLEN-1:0]           operand_a_i,
  input  logic [`LSU_XLEN-1:0]           imm_i,
  input  logic [`LSU_XLEN-1:0]           operand_b_i,
  input  logic [lsu_pkg::TRANS_ID_W-1:0] trans_id_i,
  output lsu_pkg::lsu_ctrl_t             ctrl_o
);

  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0]   vaddr;
  logic [`LSU_XLEN/8-1:0] be;
  logic                   is_store;
  logic                   misaligned;
  logic                   out_of_range;
  lsu_ctrl_t              ctrl_d;
  lsu_ctrl_t              ctrl_q;

  assign vaddr = operand_a_i + imm_i;

  assign is_store = (op_i == SB) || (op_i == SH) || (op_i == SW);

  // Bits above the 1 KiB scratchpad window
  assign out_of_range = |vaddr[`LSU_XLEN-1:`LSU_WORD_AW+2];

  // ------------------------------------------------------------
  // Byte enables and alignment
  // ------------------------------------------------------------
  always_comb begin
    case (op_i)
      LB, LBU, SB: begin
        be         = 4'b0001 << vaddr[1:0];
        misaligned = 1'b0;
      end
      LH, LHU, SH: begin
        be         = 4'b0011 << vaddr[1:0];
        misaligned = vaddr[0];
      end
      default: begin
        be         = 4'b1111;
        misaligned = |vaddr[1:0];
      end
    endcase
  end

  // ------------------------------------------------------------
  // Control stage
  // ------------------------------------------------------------
  always_comb begin
    ctrl_d          = '0;
    ctrl_d.valid    = valid_i;
    ctrl_d.vaddr    = vaddr;
    ctrl_d.be       = be;
    ctrl_d.wdata    = operand_b_i;
    ctrl_d.op       = op_i;
    ctrl_d.is_store = is_store;
    ctrl_d.trans_id = trans_id_i;
    ctrl_d.ex_valid = out_of_range | misaligned;
    // Access fault takes priority over misalignment
    if (out_of_range) begin
      ctrl_d.ex_cause = is_store ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else if (misaligned) begin
      ctrl_d.ex_cause = is_store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// File: source/lsu_macros.svh
// Sizing of the load/store unit and its data scratchpad
// LSU_WORD_AW must equal log2(LSU_DMEM_WORDS)
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Data and address width
`define LSU_XLEN 32

// Scratchpad depth in 32-bit words, 1 KiB in total
`define LSU_DMEM_WORDS 256

// Word index width into the scratchpad
`define LSU_WORD_AW 8

// Output register stages of the result streams
`define LSU_LOAD_PIPE 1
`define LSU_STORE_PIPE 1

`endif

// File: source/lsu_pkg.sv
// Types shared by the load/store unit
// Addresses are identity mapped, no MMU fields are carried
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

  localparam int unsigned TRANS_ID_W = 3;

  // Memory operations from the issue stage
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LBU = 4'd1,
    LH  = 4'd2,
    LHU = 4'd3,
    LW  = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } lsu_op_e;

  // RISC-V mcause codes for the data side
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    LD_ACCESS_FAULT    = 4'd5,
    ST_ADDR_MISALIGNED = 4'd6,
    ST_ACCESS_FAULT    = 4'd7
  } exc_cause_e;

  // Registered control stage after the AGU
  typedef struct packed {
    logic                      valid;
    logic [`LSU_XLEN-1:0]      vaddr;
    logic [`LSU_XLEN/8-1:0]    be;
    logic [`LSU_XLEN-1:0]      wdata;
    lsu_op_e                   op;
    logic                      is_store;
    logic [TRANS_ID_W-1:0]     trans_id;
    logic                      ex_valid;
    exc_cause_e                ex_cause;
  } lsu_ctrl_t;

  typedef struct packed {
    logic                 valid;
    exc_cause_e           cause;
    logic [`LSU_XLEN-1:0] tval;
  } lsu_exc_t;

  typedef struct packed {
    logic                  valid;
    logic [TRANS_ID_W-1:0] trans_id;
    logic [`LSU_XLEN-1:0]  data;
    lsu_exc_t              ex;
  } ld_result_t;

  typedef struct packed {
    logic                  valid;
    logic [TRANS_ID_W-1:0] trans_id;
    lsu_exc_t              ex;
  } st_result_t;

endpackage

`default_nettype wire

// File: source/lsu_top.sv
// Load/store unit for a 32-bit core with a private scratchpad
// Always ready, results come back 3 cycles after issue in each stream
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module lsu_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           valid_i,
  input  lsu_pkg::lsu_op_e               op_i,
  input  logic [`LSU_XLEN-1:0]           operand_a_i,
  input  logic [`LSU_XLEN-1:0]           imm_i,
  input  logic [`LSU_XLEN-1:0]           operand_b_i,
  input  logic [lsu_pkg::TRANS_ID_W-1:0] trans_id_i,
  output logic                           load_valid_o,
  output logic [lsu_pkg::TRANS_ID_W-1:0] load_trans_id_o,
  output logic [`LSU_XLEN-1:0]           load_result_o,
  output logic                           load_ex_valid_o,
  output logic [3:0]                     load_ex_cause_o,
  output logic [`LSU_XLEN-1:0]           load_ex_tval_o,
  output logic                           store_valid_o,
  output logic [lsu_pkg::TRANS_ID_W-1:0] store_trans_id_o,
  output logic                           store_ex_valid_o,
  output logic [3:0]                     store_ex_cause_o,
  output logic [`LSU_XLEN-1:0]           store_ex_tval_o
);

  import lsu_pkg::*;

  lsu_ctrl_t  ctrl;
  ld_result_t ld_res;
  ld_result_t ld_out;
  st_result_t st_res;
  st_result_t st_out;

  mem_port_if ld_port ();
  mem_port_if st_port ();

  // ------------------------------------------------------------
  // Address generation and execution
  // ------------------------------------------------------------
  lsu_agu agu_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .imm_i       (imm_i),
    .operand_b_i (operand_b_i),
    .trans_id_i  (trans_id_i),
    .ctrl_o      (ctrl)
  );

  load_unit load_unit_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ctrl_i   (ctrl),
    .mem      (ld_port),
    .result_o (ld_res)
  );

  store_unit store_unit_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ctrl_i   (ctrl),
    .mem      (st_port),
    .result_o (st_res)
  );

  dmem_bank dmem_i (
    .clk_i   (clk_i),
    .ld_port (ld_port),
    .st_port (st_port)
  );

  // ------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------
  pipe_reg #(
    .payload_t (ld_result_t),
    .DEPTH     (`LSU_LOAD_PIPE)
  ) load_pipe_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_res),
    .d_o    (ld_out)
  );

  pipe_reg #(
    .payload_t (st_result_t),
    .DEPTH     (`LSU_STORE_PIPE)
  ) store_pipe_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_res),
    .d_o    (st_out)
  );

  assign load_valid_o     = ld_out.valid;
  assign load_trans_id_o  = ld_out.trans_id;
  assign load_result_o    = ld_out.data;
  assign load_ex_valid_o  = ld_out.ex.valid;
  assign load_ex_cause_o  = ld_out.ex.cause;
  assign load_ex_tval_o   = ld_out.ex.tval;

  assign store_valid_o    = st_out.valid;
  assign store_trans_id_o = st_out.trans_id;
  assign store_ex_valid_o = st_out.ex.valid;
  assign store_ex_cause_o = st_out.ex.cause;
  assign store_ex_tval_o  = st_out.ex.tval;

endmodule

`default_nettype wire

// File: source/mem_port_if.sv
// One scratchpad request per cycle, read data returns a cycle later
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

interface mem_port_if;

  logic                   req;
  logic                   we;
  logic [`LSU_WORD_AW-1:0] addr;
  logic [`LSU_XLEN/8-1:0] be;
  logic [`LSU_XLEN-1:0]   wdata;
  logic [`LSU_XLEN-1:0]   rdata;

  // Requesting side
  modport unit (output req, we, addr, be, wdata, input rdata);

  // Memory side
  modport mem (input req, we, addr, be, wdata, output rdata);

endinterface

`default_nettype wire

// File: source/pipe_reg.sv
// Resettable register chain for any payload, DEPTH of 0 passes straight through
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t d_i,
  output payload_t d_o
);

  if (DEPTH == 0) begin : gen_pass
    assign d_o = d_i;
  end else begin : gen_regs
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= d_i;
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign d_o = stage_q[DEPTH-1];
  end

endmodule

`default_nettype wire

// File: source/store_unit.sv
// Scratchpad stores, written in the control-stage cycle
// No store buffer, so a store completes as soon as it is written
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module store_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lsu_pkg::lsu_ctrl_t  ctrl_i,
  mem_port_if.unit            mem,
  output lsu_pkg::st_result_t result_o
);

  import lsu_pkg::*;

  logic                  is_store;
  logic [`LSU_XLEN-1:0]  lane_data;
  logic                  valid_q;
  logic                  ex_q;
  logic [TRANS_ID_W-1:0] trans_id_q;
  exc_cause_e            cause_q;
  logic [`LSU_XLEN-1:0]  addr_q;

  assign is_store = ctrl_i.valid & ctrl_i.is_store;

  // Replicate the data so every byte enable sees its lane
  always_comb begin
    case (ctrl_i.op)
      SB:      lane_data = {4{ctrl_i.wdata[7:0]}};
      SH:      lane_data = {2{ctrl_i.wdata[15:0]}};
      default: lane_data = ctrl_i.wdata;
    endcase
  end

  assign mem.req   = is_store & ~ctrl_i.ex_valid;
  assign mem.we    = 1'b1;
  assign mem.addr  = ctrl_i.vaddr[`LSU_WORD_AW+1:2];
  assign mem.be    = ctrl_i.be;
  assign mem.wdata = lane_data;

  // Completion record, taken together with the write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      ex_q    <= 1'b0;
    end else begin
      valid_q <= is_store;
      ex_q    <= is_store & ctrl_i.ex_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_store) begin
      trans_id_q <= ctrl_i.trans_id;
      cause_q    <= ctrl_i.ex_cause;
      addr_q     <= ctrl_i.vaddr;
    end
  end

  always_comb begin
    result_o = '0;
    if (valid_q) begin
      result_o.valid    = 1'b1;
      result_o.trans_id = trans_id_q;
      result_o.ex.valid = ex_q;
      if (ex_q) begin
        result_o.ex.cause = cause_q;
        result_o.ex.tval  = addr_q;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_lsu.sv
// Self-checking testbench for the load/store unit, results checked against a byte model
// The scratchpad has no reset, so every word is written before any load reads it
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module tb_lsu;

  import lsu_pkg::*;

  localparam int unsigned MEM_BYTES = `LSU_DMEM_WORDS * 4;
  localparam int unsigned LATENCY   = 3;

  // One expected result, due in a known cycle
  typedef struct packed {
    logic [TRANS_ID_W-1:0] tid;
    logic [31:0]           data;
    logic                  ex;
    logic [3:0]            cause;
    logic [31:0]           tval;
    int unsigned           due;
  } expect_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  valid_i;
  lsu_op_e               op_i;
  logic [31:0]           operand_a_i;
  logic [31:0]           imm_i;
  logic [31:0]           operand_b_i;
  logic [TRANS_ID_W-1:0] trans_id_i;
  logic                  load_valid_o;
  logic [TRANS_ID_W-1:0] load_trans_id_o;
  logic [31:0]           load_result_o;
  logic                  load_ex_valid_o;
  logic [3:0]            load_ex_cause_o;
  logic [31:0]           load_ex_tval_o;
  logic                  store_valid_o;
  logic [TRANS_ID_W-1:0] store_trans_id_o;
  logic                  store_ex_valid_o;
  logic [3:0]            store_ex_cause_o;
  logic [31:0]           store_ex_tval_o;

  logic [7:0]            model [MEM_BYTES];
  expect_t               ld_q [$];
  expect_t               st_q [$];
  logic [TRANS_ID_W-1:0] next_tid = '0;
  int unsigned           cycle = 0;
  int unsigned           checks = 0;
  int unsigned           errors = 0;
  int unsigned           timeouts = 0;

  lsu_top dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .valid_i          (valid_i),
    .op_i             (op_i),
    .operand_a_i      (operand_a_i),
    .imm_i            (imm_i),
    .operand_b_i      (operand_b_i),
    .trans_id_i       (trans_id_i),
    .load_valid_o     (load_valid_o),
    .load_trans_id_o  (load_trans_id_o),
    .load_result_o    (load_result_o),
    .load_ex_valid_o  (load_ex_valid_o),
    .load_ex_cause_o  (load_ex_cause_o),
    .load_ex_tval_o   (load_ex_tval_o),
    .store_valid_o    (store_valid_o),
    .store_trans_id_o (store_trans_id_o),
    .store_ex_valid_o (store_ex_valid_o),
    .store_ex_cause_o (store_ex_cause_o),
    .store_ex_tval_o  (store_ex_tval_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] load_value(input lsu_op_e op, input logic [31:0] addr);
    logic [9:0] a;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    a  = addr[9:0];
    b0 = model[a];
    b1 = model[a + 10'd1];
    b2 = model[a + 10'd2];
    b3 = model[a + 10'd3];
    case (op)
      LB:      return {{24{b0[7]}}, b0};
      LBU:     return {24'h0, b0};
      LH:      return {{16{b1[7]}}, b1, b0};
      LHU:     return {16'h0, b1, b0};
      default: return {b3, b2, b1, b0};
    endcase
  endfunction

  task automatic write_model(input lsu_op_e op, input logic [9:0] a, input logic [31:0] b);
    model[a] = b[7:0];
    if (op != SB) begin
      model[a + 10'd1] = b[15:8];
    end
    if (op == SW) begin
      model[a + 10'd2] = b[23:16];
      model[a + 10'd3] = b[31:24];
    end
  endtask

  // Expected record is built at issue time, in program order
  task automatic issue_op(input lsu_op_e op, input logic [31:0] a, input logic [31:0] imm,
                          input logic [31:0] b);
    logic [31:0] addr;
    logic        is_st;
    logic        fault;
    logic        mis;
    expect_t     rec;
    addr  = a + imm;
    is_st = (op == SB) || (op == SH) || (op == SW);
    fault = |addr[31:10];
    mis   = ((op == LH || op == LHU || op == SH) && addr[0]) ||
            ((op == LW || op == SW) && addr[1:0] != 2'b00);
    rec     = '0;
    rec.tid = next_tid;
    rec.ex  = fault | mis;
    if (fault) begin
      rec.cause = is_st ? 4'd7 : 4'd5;
    end else if (mis) begin
      rec.cause = is_st ? 4'd6 : 4'd4;
    end
    if (rec.ex) begin
      rec.tval = addr;
    end else if (!is_st) begin
      rec.data = load_value(op, addr);
    end else begin
      write_model(op, addr[9:0], b);
    end
    @(posedge clk_i);
    rec.due     = cycle + LATENCY;
    valid_i     <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    imm_i       <= imm;
    operand_b_i <= b;
    trans_id_i  <= next_tid;
    next_tid++;
    if (is_st) begin
      st_q.push_back(rec);
    end else begin
      ld_q.push_back(rec);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      valid_i <= 1'b0;
    end
  endtask

  task automatic drain_results;
    int wait_cnt;
    idle_cycles(1);
    for (wait_cnt = 0; wait_cnt < 20 && (ld_q.size() != 0 || st_q.size() != 0); wait_cnt++) begin
      @(posedge clk_i);
    end
    if (ld_q.size() != 0 || st_q.size() != 0) begin
      timeouts++;
      $display("Timeout: %0d load and %0d store results never arrived", ld_q.size(), st_q.size());
      ld_q.delete();
      st_q.delete();
    end
  endtask

  // ------------------------------------------------------------
  // Checking, at the falling edge where outputs are stable
  // ------------------------------------------------------------
  task automatic compare_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_loads;
    expect_t rec;
    if (load_valid_o) begin
      assert (ld_q.size() != 0) else begin
        errors++;
        $display("Load result at %0t with no load outstanding", $time);
      end
      if (ld_q.size() != 0) begin
        rec = ld_q.pop_front();
        compare_field("load_valid_o cycle", cycle, rec.due);
        compare_field("load_trans_id_o", 32'(load_trans_id_o), 32'(rec.tid));
        compare_field("load_result_o", load_result_o, rec.data);
        compare_field("load_ex_valid_o", 32'(load_ex_valid_o), 32'(rec.ex));
        compare_field("load_ex_cause_o", 32'(load_ex_cause_o), 32'(rec.cause));
        compare_field("load_ex_tval_o", load_ex_tval_o, rec.tval);
      end
    end else begin
      compare_field("load_ex_valid_o", 32'(load_ex_valid_o), 32'h0);
      assert (ld_q.size() == 0 || ld_q[0].due != cycle) else begin
        errors++;
        $display("Load result for trans_id %0d missing at %0t", ld_q[0].tid, $time);
        rec = ld_q.pop_front();
      end
    end
  endtask

  task automatic check_stores;
    expect_t rec;
    if (store_valid_o) begin
      assert (st_q.size() != 0) else begin
        errors++;
        $display("Store completion at %0t with no store outstanding", $time);
      end
      if (st_q.size() != 0) begin
        rec = st_q.pop_front();
        compare_field("store_valid_o cycle", cycle, rec.due);
        compare_field("store_trans_id_o", 32'(store_trans_id_o), 32'(rec.tid));
        compare_field("store_ex_valid_o", 32'(store_ex_valid_o), 32'(rec.ex));
        compare_field("store_ex_cause_o", 32'(store_ex_cause_o), 32'(rec.cause));
        compare_field("store_ex_tval_o", store_ex_tval_o, rec.tval);
      end
    end else begin
      compare_field("store_ex_valid_o", 32'(store_ex_valid_o), 32'h0);
      assert (st_q.size() == 0 || st_q[0].due != cycle) else begin
        errors++;
        $display("Store completion for trans_id %0d missing at %0t", st_q[0].tid, $time);
        rec = st_q.pop_front();
      end
    end
  endtask

  always @(negedge clk_i) begin
    check_loads();
    check_stores();
    cycle = cycle + 1;
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    lsu_op_e     op;
    logic [31:0] a;
    logic [31:0] imm;
    void'($urandom(95));
    rst_ni      <= 1'b0;
    valid_i     <= 1'b0;
    op_i        <= LW;
    operand_a_i <= '0;
    imm_i       <= '0;
    operand_b_i <= '0;
    trans_id_i  <= '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    idle_cycles(4);

    // Fill every word so no load returns unknown data
    for (int w = 0; w < `LSU_DMEM_WORDS; w++) begin
      issue_op(SW, w * 4, 32'h0, $urandom);
    end
    drain_results();

    // Each size and signedness, loads right behind the store
    issue_op(SB, 32'h41, 32'h0, 32'h1234_56F0);
    issue_op(LB, 32'h41, 32'h0, 32'h0);
    issue_op(LBU, 32'h41, 32'h0, 32'h0);
    issue_op(SB, 32'h43, 32'h0, 32'h0000_007F);
    issue_op(LB, 32'h40, 32'h3, 32'h0);
    issue_op(LW, 32'h40, 32'h0, 32'h0);
    issue_op(SH, 32'h82, 32'h0, 32'hABCD_8001);
    issue_op(LH, 32'h82, 32'h0, 32'h0);
    issue_op(LHU, 32'h82, 32'h0, 32'h0);
    issue_op(SW, 32'h104, 32'hFFFF_FFFC, 32'hDEAD_BEEF);
    issue_op(LW, 32'h100, 32'h0, 32'h0);
    issue_op(LHU, 32'h102, 32'h0, 32'h0);
    drain_results();
    idle_cycles(3);

    // Misaligned accesses, then loads showing memory is untouched
    issue_op(LH, 32'h201, 32'h0, 32'h0);
    issue_op(LW, 32'h202, 32'h0, 32'h0);
    issue_op(SH, 32'h203, 32'h0, 32'h5555_AAAA);
    issue_op(SW, 32'h206, 32'h0, 32'h1111_2222);
    issue_op(LW, 32'h200, 32'h0, 32'h0);
    issue_op(LW, 32'h204, 32'h0, 32'h0);
    drain_results();

    // Out of range, also when misaligned
    issue_op(LW, 32'h3FC, 32'h4, 32'h0);
    issue_op(SB, 32'h1000, 32'h0, 32'h77);
    issue_op(LH, 32'h401, 32'h0, 32'h0);
    issue_op(SW, 32'hFFFF_FFFE, 32'h0, 32'h0);
    issue_op(LBU, 32'h3FF, 32'h0, 32'h0);
    drain_results();
    idle_cycles(3);

    // Random mix with no idle cycles
    for (int n = 0; n < 300; n++) begin
      op = lsu_op_e'(4'($urandom_range(7, 0)));
      a  = 32'($urandom_range(MEM_BYTES - 1, 0));
      if ($urandom_range(7, 0) != 0) begin
        if (op == LW || op == SW) begin
          a = a & ~32'h3;
        end else if (op == LH || op == LHU || op == SH) begin
          a = a & ~32'h1;
        end
      end
      imm = ($urandom_range(15, 0) == 0) ? 32'h400 : 32'h0;
      issue_op(op, a, imm, $urandom);
    end
    drain_results();
    idle_cycles(4);

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
